/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps --top-module tb_hexdump -f verilog.f

out=$(./obj_dir/Vtb_hexdump)
echo "$out"

if echo "$out" | grep -qF 'All tests passed!'; then
    exit 0
fi
exit 1

/* source/bit_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hexdump_settings.svh"

module bit_buffer (
    input  wire                     MCLK,
    input  wire hexdump_pkg::buf_wr_t wr,
    input  wire [`BUF_BYTE_AW-1:0]  rd_addr,
    output logic [7:0]              rd_data
);

    logic [7:0] mem [0:(1 << `BUF_BYTE_AW)-1];

    // upper address bits pick the byte, low three the bit inside it
    always_ff @(posedge MCLK) begin
        if (wr.en) begin
            mem[wr.addr[`BUF_BIT_AW-1:3]][wr.addr[2:0]] <= wr.data;
        end
    end

    always_ff @(posedge MCLK) begin
        rd_data <= mem[rd_addr];    // one cycle read latency
    end

endmodule

`default_nettype wire

/* source/dump_counter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hexdump_settings.svh"

module dump_counter (
    input  wire                         MCLK,
    input  wire                         rst,
    input  wire hexdump_pkg::cnt_ctrl_t ctrl,
    output hexdump_pkg::cnt_stat_t      stat,
    output logic [`BUF_BYTE_AW-1:0]     rd_addr
);

    localparam int LINE_MAX = (`LINES_BOOT > `LINES_USER) ? `LINES_BOOT : `LINES_USER;
    localparam int LINE_W   = $clog2(LINE_MAX + 1);
    localparam int BYTE_W   = $clog2(`BYTES_PER_LINE + 1);

    logic [LINE_W-1:0] line_cnt;    // lines still to print
    logic [BYTE_W-1:0] byte_cnt;    // entries done in this line

    always_ff @(posedge MCLK) begin
        if (rst) begin
            line_cnt       <= '0;
            byte_cnt       <= '0;
            rd_addr        <= '0;
            stat.line_done <= 1'b0;
            stat.dump_done <= 1'b0;
        end else if (ctrl.start) begin
            line_cnt       <= (ctrl.mode == hexdump_pkg::MODE_USER) ?
                              LINE_W'(`LINES_USER) : LINE_W'(`LINES_BOOT);
            byte_cnt       <= '0;
            rd_addr        <= '0;
            stat.line_done <= 1'b0;
            stat.dump_done <= 1'b0;
        end else if (ctrl.next_byte) begin
            rd_addr  <= rd_addr + 1'b1;
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == BYTE_W'(`BYTES_PER_LINE - 1)) begin
                stat.line_done <= 1'b1;
            end
        end else if (ctrl.next_line) begin
            line_cnt       <= line_cnt - 1'b1;
            byte_cnt       <= '0;
            stat.line_done <= 1'b0;
            if (line_cnt == LINE_W'(1)) begin
                stat.dump_done <= 1'b1;     // that was the last line
            end
        end
    end

    // the sequencer must respect the line and dump boundaries
    assert property (@(posedge MCLK) disable iff (rst)
        ctrl.next_byte |-> !stat.line_done)
        else $error("next_byte after line_done");

    assert property (@(posedge MCLK) disable iff (rst)
        ctrl.next_line |-> !stat.dump_done)
        else $error("next_line after dump_done");

endmodule

`default_nettype wire

/* source/dump_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module dump_sequencer (
    input  wire                         MCLK,
    input  wire                         rst,
    input  wire                         send_boot,
    input  wire                         send_user,
    output hexdump_pkg::char_req_t      req,
    input  wire                         tx_done,
    input  wire                         tx_abort,
    output hexdump_pkg::cnt_ctrl_t      cnt,
    input  wire hexdump_pkg::cnt_stat_t stat,
    output hexdump_pkg::dump_mode_e     mode
);

    hexdump_pkg::dump_state_e state, state_next;
    hexdump_pkg::dump_state_e ret_state, ret_next;     // where to go after tx_done
    logic                     outstanding;

    always_ff @(posedge MCLK) begin
        if (rst) begin
            state     <= hexdump_pkg::ST_IDLE;
            ret_state <= hexdump_pkg::ST_IDLE;
            mode      <= hexdump_pkg::MODE_BOOT;
        end else begin
            state     <= state_next;
            ret_state <= ret_next;
            if (state == hexdump_pkg::ST_IDLE && (send_boot || send_user)) begin
                mode <= send_boot ? hexdump_pkg::MODE_BOOT : hexdump_pkg::MODE_USER;
            end
        end
    end

    always_comb begin
        state_next = state;
        ret_next   = ret_state;
        req.strobe = 1'b0;
        req.op     = hexdump_pkg::OP_SPACE;
        case (state)
            hexdump_pkg::ST_IDLE: begin
                if (send_boot || send_user) begin
                    state_next = hexdump_pkg::ST_START;
                end
            end
            hexdump_pkg::ST_START: begin
                state_next = (mode == hexdump_pkg::MODE_USER) ?
                             hexdump_pkg::ST_PAGE2 : hexdump_pkg::ST_CHECK;
            end
            hexdump_pkg::ST_PAGE2: begin
                req.strobe = 1'b1;
                req.op     = hexdump_pkg::OP_PAGE2;
                ret_next   = hexdump_pkg::ST_PAGE1;
            end
            hexdump_pkg::ST_PAGE1: begin
                req.strobe = 1'b1;
                req.op     = hexdump_pkg::OP_PAGE1;
                ret_next   = hexdump_pkg::ST_PAGE0;
            end
            hexdump_pkg::ST_PAGE0: begin
                req.strobe = 1'b1;
                req.op     = hexdump_pkg::OP_PAGE0;
                ret_next   = hexdump_pkg::ST_PAGE_EOL;
            end
            hexdump_pkg::ST_PAGE_EOL: begin
                req.strobe = 1'b1;
                req.op     = hexdump_pkg::OP_EOL;
                ret_next   = hexdump_pkg::ST_CHECK;
            end
            // one spare cycle here lets the byte read settle
            hexdump_pkg::ST_CHECK: begin
                state_next = stat.line_done ? hexdump_pkg::ST_EOL : hexdump_pkg::ST_HI;
            end
            hexdump_pkg::ST_HI: begin
                req.strobe = 1'b1;
                req.op     = hexdump_pkg::OP_HI_NIBBLE;
                ret_next   = hexdump_pkg::ST_LO;
            end
            hexdump_pkg::ST_LO: begin
                req.strobe = 1'b1;
                req.op     = hexdump_pkg::OP_LO_NIBBLE;
                ret_next   = hexdump_pkg::ST_SPACE;
            end
            hexdump_pkg::ST_SPACE: begin
                req.strobe = 1'b1;
                req.op     = hexdump_pkg::OP_SPACE;
                ret_next   = hexdump_pkg::ST_NEXT_BYTE;
            end
            hexdump_pkg::ST_NEXT_BYTE: state_next = hexdump_pkg::ST_CHECK;
            hexdump_pkg::ST_EOL: begin
                req.strobe = 1'b1;
                req.op     = hexdump_pkg::OP_EOL;
                ret_next   = hexdump_pkg::ST_NEXT_LINE;
            end
            hexdump_pkg::ST_NEXT_LINE: state_next = hexdump_pkg::ST_LINE_CHECK;
            hexdump_pkg::ST_LINE_CHECK: begin
                state_next = stat.dump_done ? hexdump_pkg::ST_FINAL_EOL : hexdump_pkg::ST_HI;
            end
            hexdump_pkg::ST_FINAL_EOL: begin
                req.strobe = 1'b1;
                req.op     = hexdump_pkg::OP_EOL;
                ret_next   = hexdump_pkg::ST_DONE;
            end
            hexdump_pkg::ST_WAIT: begin
                if (tx_abort) begin
                    state_next = hexdump_pkg::ST_IDLE;
                end else if (tx_done) begin
                    state_next = ret_state;
                end
            end
            hexdump_pkg::ST_DONE: begin
                if (!send_boot && !send_user) begin
                    state_next = hexdump_pkg::ST_IDLE;
                end
            end
            default: state_next = hexdump_pkg::ST_IDLE;
        endcase
        if (req.strobe) begin
            state_next = hexdump_pkg::ST_WAIT;  // every char goes out before the next step
        end
    end

    assign cnt.start     = (state == hexdump_pkg::ST_START);
    assign cnt.mode      = mode;
    assign cnt.next_byte = (state == hexdump_pkg::ST_NEXT_BYTE);
    assign cnt.next_line = (state == hexdump_pkg::ST_NEXT_LINE);

    // a char is in flight from its strobe until the write port answers
    always_ff @(posedge MCLK) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (req.strobe) begin
            outstanding <= 1'b1;
        end else if (tx_done || tx_abort) begin
            outstanding <= 1'b0;
        end
    end

    assert property (@(posedge MCLK) disable iff (rst)
        req.strobe |-> !outstanding)
        else $error("char request while a byte is outstanding");

endmodule

`default_nettype wire

/* source/ft_write_port.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hexdump_settings.svh"

module ft_write_port (
    input  wire                       MCLK,
    input  wire                       rst,
    input  wire hexdump_pkg::tx_req_t tx,
    input  wire                       txe_n,
    input  wire                       send_boot,
    input  wire                       send_user,
    output logic [7:0]                data,
    output logic                      wr_n,
    output logic                      tx_done,
    output logic                      tx_abort
);

    typedef enum logic [1:0] {WP_IDLE, WP_WAIT, WP_LOW} wp_state_e;

    localparam int CNT_W = $clog2(`WR_LOW_CYCLES + 1);

    wp_state_e        state;
    logic [CNT_W-1:0] low_cnt;

    always_ff @(posedge MCLK) begin
        if (rst) begin
            state    <= WP_IDLE;
            wr_n     <= 1'b1;
            tx_done  <= 1'b0;
            tx_abort <= 1'b0;
            low_cnt  <= '0;
        end else begin
            tx_done  <= 1'b0;
            tx_abort <= 1'b0;
            case (state)
                WP_IDLE: begin
                    if (tx.strobe) begin
                        state <= WP_WAIT;
                    end
                end
                WP_WAIT: begin
                    if (!send_boot && !send_user) begin
                        state    <= WP_IDLE;    // host gave up, drop the byte
                        tx_abort <= 1'b1;
                    end else if (!txe_n) begin
                        state   <= WP_LOW;
                        wr_n    <= 1'b0;
                        low_cnt <= '0;
                    end
                end
                WP_LOW: begin
                    if (low_cnt == CNT_W'(`WR_LOW_CYCLES - 1)) begin
                        state   <= WP_IDLE;
                        wr_n    <= 1'b1;
                        tx_done <= 1'b1;
                    end else begin
                        low_cnt <= low_cnt + 1'b1;
                    end
                end
                default: state <= WP_IDLE;
            endcase
        end
    end

    // byte held on the pins from accept until the next accept
    always_ff @(posedge MCLK) begin
        if (state == WP_IDLE && tx.strobe) begin
            data <= tx.data;
        end
    end

    assert property (@(posedge MCLK) disable iff (rst)
        $fell(wr_n) |-> !wr_n [*`WR_LOW_CYCLES] ##1 wr_n)
        else $error("wr_n low pulse has wrong length");

endmodule

`default_nettype wire

/* source/hex_formatter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hexdump_settings.svh"

module hex_formatter (
    input  wire                         MCLK,
    input  wire                         rst,
    input  wire hexdump_pkg::char_req_t req,
    input  wire [7:0]                   rd_data,
    input  wire [`PAGE_W-1:0]           page,
    input  wire                         start,
    output hexdump_pkg::tx_req_t        tx
);

    logic [`PAGE_W-1:0] page_q;     // page frozen for the whole dump
    logic [7:0]         char_byte;
    logic [7:0]         data_q;
    logic               strobe_q;

    function automatic logic [7:0] hex_ascii(input logic [3:0] nib);
        return (nib < 4'd10) ? (8'h30 + {4'h0, nib}) : (8'h37 + {4'h0, nib});
    endfunction

    always_comb begin
        case (req.op)
            hexdump_pkg::OP_PAGE2:     char_byte = hex_ascii(page_q[8 +: 4]);
            hexdump_pkg::OP_PAGE1:     char_byte = hex_ascii(page_q[4 +: 4]);
            hexdump_pkg::OP_PAGE0:     char_byte = hex_ascii(page_q[0 +: 4]);
            hexdump_pkg::OP_HI_NIBBLE: char_byte = hex_ascii(rd_data[7:4]);
            hexdump_pkg::OP_LO_NIBBLE: char_byte = hex_ascii(rd_data[3:0]);
            hexdump_pkg::OP_SPACE:     char_byte = `CHAR_SPACE;
            default:                   char_byte = `CHAR_EOL;
        endcase
    end

    always_ff @(posedge MCLK) begin
        if (start) begin
            page_q <= page;
        end
        if (req.strobe) begin
            data_q <= char_byte;
        end
    end

    always_ff @(posedge MCLK) begin
        if (rst) begin
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= req.strobe;     // byte valid one cycle after the request
        end
    end

    assign tx.strobe = strobe_q;
    assign tx.data   = data_q;

endmodule

`default_nettype wire

/* source/hexdump_pkg.sv */
`default_nettype none

`include "hexdump_settings.svh"

package hexdump_pkg;

    typedef enum logic [4:0] {
        ST_IDLE, ST_START,
        ST_PAGE2, ST_PAGE1, ST_PAGE0, ST_PAGE_EOL,
        ST_CHECK, ST_HI, ST_LO, ST_SPACE, ST_NEXT_BYTE,
        ST_EOL, ST_NEXT_LINE, ST_LINE_CHECK, ST_FINAL_EOL,
        ST_WAIT, ST_DONE
    } dump_state_e;

    typedef enum logic {MODE_BOOT, MODE_USER} dump_mode_e;

    typedef enum logic [2:0] {
        OP_PAGE2, OP_PAGE1, OP_PAGE0, OP_HI_NIBBLE, OP_LO_NIBBLE, OP_SPACE, OP_EOL
    } char_op_e;

    typedef struct packed {
        logic                   en;
        logic [`BUF_BIT_AW-1:0] addr;
        logic                   data;
    } buf_wr_t;

    typedef struct packed {
        logic     strobe;
        char_op_e op;
    } char_req_t;

    typedef struct packed {
        logic       strobe;
        logic [7:0] data;
    } tx_req_t;

    typedef struct packed {
        logic       start;
        dump_mode_e mode;
        logic       next_byte;
        logic       next_line;
    } cnt_ctrl_t;

    typedef struct packed {
        logic line_done;
        logic dump_done;
    } cnt_stat_t;

endpackage

`default_nettype wire

/* source/hexdump_settings.svh */
`ifndef HEXDUMP_SETTINGS_SVH
`define HEXDUMP_SETTINGS_SVH

// 8k buffer bits written one at a time and read back as 1k bytes
`define BUF_BIT_AW      13
`define BUF_BYTE_AW     10

`define PAGE_W          12      // three hex digits on the page line

// dump layout
`define BYTES_PER_LINE  16
`define LINES_USER      8
`define LINES_BOOT      30

// ascii codes
`define CHAR_SPACE      8'h20
`define CHAR_EOL        8'h0D

`define WR_LOW_CYCLES   2       // wr_n low time in MCLK cycles

`endif

/* source/hexdump_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hexdump_settings.svh"

module hexdump_top (
    input  wire                       MCLK,
    input  wire                       rst,
    input  wire hexdump_pkg::buf_wr_t buf_wr,
    input  wire                       send_boot,
    input  wire                       send_user,
    input  wire [`PAGE_W-1:0]         curr_page,
    input  wire                       txe_n,
    output logic [7:0]                data,
    output logic                      wr_n
);

    logic [`BUF_BYTE_AW-1:0] rd_addr;
    logic [7:0]              rd_data;
    hexdump_pkg::char_req_t  char_req;
    hexdump_pkg::tx_req_t    tx_req;
    hexdump_pkg::cnt_ctrl_t  cnt_ctrl;
    hexdump_pkg::cnt_stat_t  cnt_stat;
    logic                    tx_done;
    logic                    tx_abort;

    bit_buffer u_buf (
        .MCLK    (MCLK),
        .wr      (buf_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    dump_counter u_cnt (
        .MCLK    (MCLK),
        .rst     (rst),
        .ctrl    (cnt_ctrl),
        .stat    (cnt_stat),
        .rd_addr (rd_addr)
    );

    dump_sequencer u_seq (
        .MCLK      (MCLK),
        .rst       (rst),
        .send_boot (send_boot),
        .send_user (send_user),
        .req       (char_req),
        .tx_done   (tx_done),
        .tx_abort  (tx_abort),
        .cnt       (cnt_ctrl),
        .stat      (cnt_stat),
        .mode      ()
    );

    hex_formatter u_fmt (
        .MCLK    (MCLK),
        .rst     (rst),
        .req     (char_req),
        .rd_data (rd_data),
        .page    (curr_page),
        .start   (cnt_ctrl.start),
        .tx      (tx_req)
    );

    ft_write_port u_port (
        .MCLK      (MCLK),
        .rst       (rst),
        .tx        (tx_req),
        .txe_n     (txe_n),
        .send_boot (send_boot),
        .send_user (send_user),
        .data      (data),
        .wr_n      (wr_n),
        .tx_done   (tx_done),
        .tx_abort  (tx_abort)
    );

endmodule

`default_nettype wire

/* verif/tb_hexdump.sv */
`timescale 1ns/100ps
`default_nettype none

`include "hexdump_settings.svh"

module tb_hexdump;

    localparam int IDLE_LIMIT = 300;    // cycles without a byte before giving up
    localparam int FILL_BITS  = `LINES_BOOT * `BYTES_PER_LINE * 8;

    logic                 MCLK;
    logic                 rst;
    hexdump_pkg::buf_wr_t buf_wr;
    logic                 send_boot;
    logic                 send_user;
    logic [`PAGE_W-1:0]   curr_page;
    logic                 txe_n = 1'b1;
    logic [7:0]           data;
    logic                 wr_n;

    logic [7:0] ref_mem [0:(1 << `BUF_BYTE_AW)-1];     // copy of what was written
    logic [7:0] exp_q [$];                              // bytes still to come
    integer     seed = 32'hd3a2;
    logic       txe_hold;
    int         errors = 0;
    int         timeouts = 0;
    int         checked = 0;
    logic       wr_n_q;
    logic [7:0] data_at_fall;
    int         low_cycles = 0;

    hexdump_top uut (
        .MCLK      (MCLK),
        .rst       (rst),
        .buf_wr    (buf_wr),
        .send_boot (send_boot),
        .send_user (send_user),
        .curr_page (curr_page),
        .txe_n     (txe_n),
        .data      (data),
        .wr_n      (wr_n)
    );

    initial MCLK = 1'b0;
    always #50 MCLK = ~MCLK;

    // FIFO model is full now and then or held full on demand
    always @(negedge MCLK) begin
        if (txe_hold) begin
            txe_n <= 1'b1;
        end else begin
            txe_n <= (($random(seed) & 3) == 0);
        end
    end

    function automatic logic [7:0] nibble_char(input logic [3:0] nib);
        string digits;
        digits = "0123456789ABCDEF";
        return digits[nib];
    endfunction

    task automatic check_byte();
        logic [7:0] want;
        assert (low_cycles == `WR_LOW_CYCLES) else begin
            errors++;
            $display("FAIL %0t: wr_n low for %0d cycles", $time, low_cycles);
        end
        assert (exp_q.size() > 0) else begin
            errors++;
            $display("FAIL %0t: unexpected write of %h", $time, data);
        end
        if (exp_q.size() > 0) begin
            want = exp_q.pop_front();
            checked++;
            assert (data == want) else begin
                errors++;
                $display("FAIL %0t: got byte %h, expected %h", $time, data, want);
            end
        end
    endtask

    // wr_n and data only move on the rising edge, so the falling edge sees them settled
    always @(negedge MCLK) begin
        if (rst) begin
            low_cycles = 0;
        end else if (!wr_n) begin
            if (wr_n_q) begin
                data_at_fall = data;
            end
            low_cycles++;
            assert (data == data_at_fall) else begin
                errors++;
                $display("FAIL %0t: data moved while wr_n low, %h -> %h",
                         $time, data_at_fall, data);
            end
        end else if (!wr_n_q) begin
            check_byte();
            low_cycles = 0;
        end
        wr_n_q = wr_n;
    end

    // a write starts only after txe_n was seen low
    assert property (@(posedge MCLK) disable iff (rst) $fell(wr_n) |-> $past(!txe_n))
        else begin
            errors++;
            $display("FAIL %0t: wr_n fell without txe_n low the cycle before", $time);
        end

    assert property (@(posedge MCLK) disable iff (rst)
        $fell(wr_n) |-> $past(send_boot || send_user))
        else begin
            errors++;
            $display("FAIL %0t: write started with no request", $time);
        end

    task automatic finish_run();
        $display("errors: %0d, timeouts: %0d, bytes checked: %0d", errors, timeouts, checked);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    // waits until the queue drops to level, as long as bytes keep arriving
    task automatic wait_queue_level(input int level, input string what);
        int idle;
        int last;
        idle = 0;
        last = exp_q.size();
        while (exp_q.size() > level && idle < IDLE_LIMIT) begin
            @(negedge MCLK);
            if (exp_q.size() != last) begin
                idle = 0;
                last = exp_q.size();
            end else begin
                idle++;
            end
        end
        if (exp_q.size() > level) begin
            timeouts++;
            $display("Timeout in %s: output stalled with %0d bytes still expected",
                     what, exp_q.size());
        end
    endtask

    task automatic fill_buffer(input int nbits);
        int                     a;
        int                     rnd;
        logic [`BUF_BIT_AW-1:0] addr;
        for (a = 0; a < nbits; a++) begin
            @(negedge MCLK);
            rnd  = $random(seed);
            addr = a[`BUF_BIT_AW-1:0];
            buf_wr <= '{en: 1'b1, addr: addr, data: rnd[0]};
            ref_mem[addr[`BUF_BIT_AW-1:3]][addr[2:0]] = rnd[0];
        end
        @(negedge MCLK);
        buf_wr <= '0;
    endtask

    task automatic build_expected(input logic user, input logic [`PAGE_W-1:0] page);
        int                      lines;
        int                      row;
        int                      entry;
        logic [`BUF_BYTE_AW-1:0] addr;
        exp_q.delete();
        addr  = '0;
        lines = user ? `LINES_USER : `LINES_BOOT;
        if (user) begin
            exp_q.push_back(nibble_char(page[11:8]));
            exp_q.push_back(nibble_char(page[7:4]));
            exp_q.push_back(nibble_char(page[3:0]));
            exp_q.push_back(`CHAR_EOL);
        end
        for (row = 0; row < lines; row++) begin
            for (entry = 0; entry < `BYTES_PER_LINE; entry++) begin
                exp_q.push_back(nibble_char(ref_mem[addr][7:4]));
                exp_q.push_back(nibble_char(ref_mem[addr][3:0]));
                exp_q.push_back(`CHAR_SPACE);
                addr++;
            end
            exp_q.push_back(`CHAR_EOL);
        end
        exp_q.push_back(`CHAR_EOL);     // closing empty line
    endtask

    task automatic run_dump(input logic user, input logic [`PAGE_W-1:0] page);
        build_expected(user, page);
        curr_page <= page;
        if (user) begin
            send_user <= 1'b1;
        end else begin
            send_boot <= 1'b1;
        end
        repeat (6) @(negedge MCLK);
        curr_page <= ~page;             // page is frozen by now
        wait_queue_level(0, user ? "user dump" : "boot dump");
        repeat (20) @(negedge MCLK);    // any extra byte shows up here
        send_user <= 1'b0;
        send_boot <= 1'b0;
        repeat (5) @(negedge MCLK);
    endtask

    initial begin
        rst       = 1'b1;
        buf_wr    = '0;
        send_boot = 1'b0;
        send_user = 1'b0;
        curr_page = '0;
        txe_hold  = 1'b0;
        repeat (5) @(negedge MCLK);
        rst <= 1'b0;

        @(negedge MCLK);
        assert (wr_n === 1'b1) else begin
            errors++;
            $display("FAIL %0t: wr_n is %b after reset", $time, wr_n);
        end
        repeat (20) @(negedge MCLK);    // idle, no request

        fill_buffer(FILL_BITS);
        run_dump(1'b1, 12'h5A3);
        run_dump(1'b0, 12'h000);

        // abort partway through a user dump while the FIFO is full
        build_expected(1'b1, 12'h0C7);
        curr_page <= 12'h0C7;
        send_user <= 1'b1;
        wait_queue_level(exp_q.size() - 40, "abort lead-in");
        txe_hold <= 1'b1;
        repeat (30) @(negedge MCLK);    // port must just sit and wait
        send_user <= 1'b0;
        exp_q.delete();                 // nothing may come out from here on
        repeat (30) @(negedge MCLK);
        txe_hold <= 1'b0;
        repeat (30) @(negedge MCLK);

        run_dump(1'b1, 12'hE1F);        // starts over with the page line
        finish_run();
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+source
source/hexdump_pkg.sv
source/bit_buffer.sv
source/dump_counter.sv
source/dump_sequencer.sv
source/hex_formatter.sv
source/ft_write_port.sv
source/hexdump_top.sv
verif/tb_hexdump.sv
